// ==== tb.f ====
hw/mem_eng_pkg.sv
hw/mem_eng_ctrl.sv
hw/stack_zero_engine.sv
hw/tag_scan_engine.sv
hw/lsu_port_arbiter.sv
hw/mem_eng_top.sv
testbench/mem_eng_chk.sv
testbench/tb_mem_eng.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and exit non-zero unless it passed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_eng \
  -f tb.f -o tb_mem_eng &&
./obj_dir/tb_mem_eng | tee /dev/stderr | grep -F "All tests passed!" > /dev/null ||
{ echo "Simulation did not pass" >&2; exit 1; }

// ==== testbench/tb_mem_eng.sv ====
/*
  Testbench for the memory engine subsystem with a tagged memory model.
  Runs stack zeroing, revocation scans, both at once, an abort and error cases.
*/
`timescale 1ns/1ns

module tb_mem_eng import mem_eng_pkg::*; ();

  localparam int unsigned MemWords  = 1024;
  localparam int unsigned WaitMax   = 20000;
  localparam logic [31:0] BadLo     = 32'h0000_0F00;
  localparam logic [31:0] StkTop    = 32'h0000_0800;
  localparam logic [23:0] RvkLo     = 24'h10_0000;
  localparam logic [23:0] RvkHi     = 24'h14_0000;
  localparam int          SelActive = 0;
  localparam int          SelBusy   = 1;
  localparam int          SelAbort  = 2;
  localparam int          SelPtrLow = 3;

  logic                  clk_i;
  logic                  rst_ni;
  logic [MMRegDinW-1:0]  mmreg_corein_i;
  logic [MMRegDoutW-1:0] mmreg_coreout_o;
  logic                  ztop_wr_i;
  logic [31:0]           ztop_wdata_i;
  logic [31:0]           ztop_rdata_o;
  logic                  unmasked_intr_i;
  logic                  stkz_active_o;
  logic                  stkz_abort_o;
  logic [31:0]           stkz_ptr_o;
  logic                  lsu_req_o;
  logic                  lsu_we_o;
  logic [31:0]           lsu_addr_o;
  logic [WordW-1:0]      lsu_wdata_o;
  logic                  lsu_req_done_i;
  logic                  lsu_resp_valid_i;
  logic                  lsu_resp_err_i;
  logic [WordW-1:0]      lsu_resp_rdata_i;

  logic [WordW-1:0] mem [MemWords];
  logic [31:0]      lcg_state = 32'he701;
  logic [31:0]      stk_base_cfg;
  // Address of the most recent accepted write
  logic [31:0]      last_wr_addr;
  int unsigned      errors;
  int unsigned      timeouts;
  int unsigned      ptr_idx;

  mem_eng_top #(
    .ScanCntW    (16),
    .IntrAbortEn (1'b1)
  ) DUT (.*);

  bind mem_eng_top mem_eng_chk u_chk (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (lsu_req_o),
    .we_i         (lsu_we_o),
    .addr_i       (lsu_addr_o),
    .wdata_i      (lsu_wdata_o),
    .req_done_i   (lsu_req_done_i),
    .resp_valid_i (lsu_resp_valid_i),
    .abort_i      (stkz_abort_o),
    .stkz_req_i   (stkz_req),
    .stkz_we_i    (stkz_we),
    .stkz_addr_i  (stkz_addr),
    .stkz_wdata_i (stkz_wdata)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Tag is the parity of the index, low bits spread across the revoked window
  function automatic logic [WordW-1:0] fill_word(int unsigned idx);
    return {^idx, 32'h5A00_0000 | (idx * 32'h731)};
  endfunction

  function automatic logic [WordW-1:0] expect_scanned(logic [WordW-1:0] w);
    if (w[32] && w[23:0] >= RvkLo && w[23:0] < RvkHi) begin
      return {1'b0, w[31:0]};
    end
    return w;
  endfunction

  function automatic logic [MMRegDinW-1:0] cmd_word(logic start, logic [23:0] base,
                                                    logic [15:0] count);
    logic [MMRegDinW-1:0] c;
    c = '0;
    c[CMD_SCAN_START_BIT]         = start;
    c[CMD_SCAN_BASE_LSB +: 24]    = base;
    c[CMD_SCAN_COUNT_LSB +: 16]   = count;
    c[CMD_RVK_LO_LSB +: 24]       = RvkLo;
    c[CMD_RVK_HI_LSB +: 24]       = RvkHi;
    c[CMD_STK_BASE_LSB +: 32]     = stk_base_cfg;
    return c;
  endfunction

  function automatic logic probe(int sel);
    case (sel)
      SelActive: return stkz_active_o;
      SelBusy:   return mmreg_coreout_o[STAT_SCAN_BUSY];
      SelAbort:  return stkz_abort_o;
      default:   return (stkz_ptr_o <= 32'h700);
    endcase
  endfunction

  task automatic finish_run();
    int unsigned asserts;
    asserts = DUT.u_chk.fail_cnt;
    $display("Errors: %0d value, %0d timeout, %0d assertion", errors, timeouts, asserts);
    if (errors == 0 && timeouts == 0 && asserts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic wait_until(int sel, logic level, string what);
    int n;
    n = 0;
    while (probe(sel) !== level && n < WaitMax) begin
      @(negedge clk_i);
      n++;
    end
    if (probe(sel) !== level) begin
      $display("Timeout while waiting for %s", what);
      timeouts++;
    end
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got %08h, expected %08h", name, got, exp);
    end
  endtask

  // Mode 0 expects zero, 1 the fill pattern, 2 the scanned pattern
  task automatic check_range(int unsigned lo, int unsigned hi, int mode);
    logic [WordW-1:0] exp;
    for (int unsigned i = lo; i < hi; i++) begin
      exp = (mode == 0) ? '0 : (mode == 1) ? fill_word(i) : expect_scanned(fill_word(i));
      if (mem[i] !== exp) begin
        errors++;
        $display("[FAIL] mem[%03h]: got %09h, expected %09h", i, mem[i], exp);
      end
    end
  endtask

  task automatic refill(int unsigned lo, int unsigned hi);
    for (int unsigned i = lo; i < hi; i++) begin
      mem[i] = fill_word(i);
    end
  endtask

  task automatic set_stack_base(logic [31:0] base);
    stk_base_cfg   = base;
    mmreg_corein_i = cmd_word(1'b0, 24'h0, 16'h0);
    @(negedge clk_i);
  endtask

  task automatic write_ztop(logic [31:0] top);
    ztop_wr_i    = 1'b1;
    ztop_wdata_i = top;
    @(negedge clk_i);
    ztop_wr_i    = 1'b0;
  endtask

  task automatic start_scan(logic [23:0] base, logic [15:0] count);
    mmreg_corein_i = cmd_word(1'b0, base, count);
    @(negedge clk_i);
    mmreg_corein_i = cmd_word(1'b1, base, count);
    wait_until(SelBusy, 1'b1, "scan busy to rise");
    mmreg_corein_i = cmd_word(1'b0, base, count);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Memory model, accepts after 0 to 3 cycles and answers one cycle later
  initial begin
    int unsigned delay;
    logic        have_delay;
    logic        acc_err;
    logic [WordW-1:0] acc_rdata;
    lsu_req_done_i   = 1'b0;
    lsu_resp_valid_i = 1'b0;
    lsu_resp_err_i   = 1'b0;
    lsu_resp_rdata_i = '0;
    last_wr_addr     = 32'h0;
    delay            = 0;
    have_delay       = 1'b0;
    acc_err          = 1'b0;
    acc_rdata        = '0;
    forever begin
      @(negedge clk_i);
      lsu_resp_valid_i = 1'b0;
      lsu_resp_err_i   = 1'b0;
      if (lsu_req_done_i) begin
        lsu_req_done_i   = 1'b0;
        lsu_resp_valid_i = 1'b1;
        lsu_resp_err_i   = acc_err;
        lsu_resp_rdata_i = acc_rdata;
        have_delay       = 1'b0;
      end else if (lsu_req_o) begin
        if (!have_delay) begin
          delay      = (lcg_next() >> 16) % 4;
          have_delay = 1'b1;
        end
        if (delay == 0) begin
          lsu_req_done_i = 1'b1;
          acc_err        = (lsu_addr_o >= BadLo);
          acc_rdata      = acc_err ? '0 : mem[lsu_addr_o[11:2]];
          if (lsu_we_o) begin
            last_wr_addr = lsu_addr_o;
          end
          if (lsu_we_o && !acc_err) begin
            mem[lsu_addr_o[11:2]] = lsu_wdata_o;
          end
        end else begin
          delay--;
        end
      end
    end
  end

  initial begin
    errors          = 0;
    timeouts        = 0;
    stk_base_cfg    = 32'h600;
    rst_ni          = 1'b0;
    mmreg_corein_i  = '0;
    ztop_wr_i       = 1'b0;
    ztop_wdata_i    = 32'h0;
    unmasked_intr_i = 1'b0;
    refill(0, MemWords);
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Stack zeroing on its own
    set_stack_base(32'h600);
    write_ztop(StkTop);
    wait_until(SelActive, 1'b0, "stack zeroing to finish");
    check_value("stkz_ptr_o", stkz_ptr_o, 32'h600);
    check_range(32'h17F, 32'h180, 1);
    check_range(32'h180, 32'h200, 0);
    check_range(32'h200, 32'h201, 1);

    // Revocation scan on its own
    start_scan(24'h800, 16'd128);
    wait_until(SelBusy, 1'b0, "scan to finish");
    check_range(32'h200, 32'h280, 2);
    check_range(32'h280, 32'h281, 1);

    // Both engines share the port
    refill(32'h180, 32'h200);
    write_ztop(StkTop);
    start_scan(24'hA00, 16'd128);
    wait_until(SelBusy, 1'b0, "shared scan to finish");
    wait_until(SelActive, 1'b0, "shared stack zeroing to finish");
    check_range(32'h180, 32'h200, 0);
    check_range(32'h280, 32'h300, 2);

    // Interrupt stops zeroing part way down
    set_stack_base(32'h400);
    refill(32'h100, 32'h200);
    write_ztop(StkTop);
    wait_until(SelPtrLow, 1'b1, "stack pointer to pass 0x700");
    unmasked_intr_i = 1'b1;
    @(negedge clk_i);
    unmasked_intr_i = 1'b0;
    wait_until(SelAbort, 1'b1, "stack abort pulse");
    wait_until(SelActive, 1'b0, "stack zeroing to stop");
    if (stkz_ptr_o <= 32'h400) begin
      errors++;
      $display("Abort did not leave the stack pointer above the stack base");
    end
    // Pointer stays on the last word that was zeroed
    check_value("stkz_ptr_o", stkz_ptr_o, last_wr_addr);
    check_value("ztop_rdata_o", ztop_rdata_o, last_wr_addr);
    ptr_idx = last_wr_addr >> 2;
    check_range(32'h100, ptr_idx, 1);
    check_range(ptr_idx, 32'h200, 0);

    // Error flags from the bad region, then a clean scan
    start_scan(24'hF00, 16'd8);
    wait_until(SelBusy, 1'b0, "bad-region scan to finish");
    check_value("mmreg_coreout_o[STAT_SCAN_ERR]", 32'(mmreg_coreout_o[STAT_SCAN_ERR]), 32'h1);
    start_scan(24'h800, 16'd4);
    wait_until(SelBusy, 1'b0, "clean scan to finish");
    check_value("mmreg_coreout_o[STAT_SCAN_ERR]", 32'(mmreg_coreout_o[STAT_SCAN_ERR]), 32'h0);
    set_stack_base(32'hF00);
    write_ztop(32'hF10);
    wait_until(SelActive, 1'b0, "bad-region zeroing to finish");
    @(negedge clk_i);
    check_value("mmreg_coreout_o[STAT_STK_ERR]", 32'(mmreg_coreout_o[STAT_STK_ERR]), 32'h1);

    repeat (4) @(negedge clk_i);
    finish_run();
  end

endmodule

// ==== testbench/mem_eng_chk.sv ====
/*
  Protocol checker for the shared load/store port and the stack abort flag.
  Bound into the subsystem top by the testbench.
*/
`timescale 1ns/1ns

module mem_eng_chk import mem_eng_pkg::*; (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             req_i,
  input logic             we_i,
  input logic [31:0]      addr_i,
  input logic [WordW-1:0] wdata_i,
  input logic             req_done_i,
  input logic             resp_valid_i,
  input logic             abort_i,
  input logic             stkz_req_i,
  input logic             stkz_we_i,
  input logic [31:0]      stkz_addr_i,
  input logic [WordW-1:0] stkz_wdata_i
);

  // Read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // A waiting request keeps its fields until accepted
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !req_done_i) |=>
      (req_i && $stable(we_i) && $stable(addr_i) && $stable(wdata_i)))
  else begin
    fail_cnt++;
    $error("Request fields changed before the request was accepted");
  end

  // Response comes exactly one cycle after acceptance
  resp_after_acc_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && req_done_i) |=> resp_valid_i)
  else begin
    fail_cnt++;
    $error("No response in the cycle after an accepted request");
  end

  resp_only_after_acc_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i |-> $past(req_i && req_done_i))
  else begin
    fail_cnt++;
    $error("Response without an accepted request one cycle before");
  end

  abort_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    abort_i |=> !abort_i)
  else begin
    fail_cnt++;
    $error("Stack abort flag stayed high for more than one cycle");
  end

  // A fresh decision with a stack request waiting must pick the stack engine
  stkz_first_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stkz_req_i && !$past(req_i && !req_done_i)) |->
      (we_i == stkz_we_i && addr_i == stkz_addr_i && wdata_i == stkz_wdata_i))
  else begin
    fail_cnt++;
    $error("Scan won a fresh decision while a stack request was waiting");
  end

endmodule

// ==== hw/mem_eng_top.sv ====
/*
  Memory engine subsystem: control block, stack zeroing, tag scan and the
  arbiter that shares one load/store port between the two engines.
*/
`timescale 1ns/1ns

module mem_eng_top import mem_eng_pkg::*; #(
  parameter int unsigned ScanCntW    = 16,
  parameter bit          IntrAbortEn = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic [MMRegDinW-1:0]  mmreg_corein_i,
  output logic [MMRegDoutW-1:0] mmreg_coreout_o,

  input  logic                  ztop_wr_i,
  input  logic [31:0]           ztop_wdata_i,
  output logic [31:0]           ztop_rdata_o,
  input  logic                  unmasked_intr_i,
  output logic                  stkz_active_o,
  output logic                  stkz_abort_o,
  output logic [31:0]           stkz_ptr_o,

  output logic                  lsu_req_o,
  output logic                  lsu_we_o,
  output logic [31:0]           lsu_addr_o,
  output logic [WordW-1:0]      lsu_wdata_o,
  input  logic                  lsu_req_done_i,
  input  logic                  lsu_resp_valid_i,
  input  logic                  lsu_resp_err_i,
  input  logic [WordW-1:0]      lsu_resp_rdata_i
);

  logic                scan_start;
  logic [23:0]         scan_base;
  logic [ScanCntW-1:0] scan_count;
  logic [23:0]         rvk_lo;
  logic [23:0]         rvk_hi;
  logic [31:0]         stk_base;
  logic                scan_busy;
  logic                scan_err;
  logic                stkz_err;

  logic                stkz_req, stkz_we, stkz_req_done, stkz_resp_valid;
  logic [31:0]         stkz_addr;
  logic [WordW-1:0]    stkz_wdata;
  logic                scan_req, scan_we, scan_req_done, scan_resp_valid;
  logic [31:0]         scan_addr;
  logic [WordW-1:0]    scan_wdata;

  mem_eng_ctrl #(
    .ScanCntW (ScanCntW)
  ) u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mmreg_corein_i  (mmreg_corein_i),
    .scan_busy_i     (scan_busy),
    .scan_err_i      (scan_err),
    .stk_err_i       (stkz_err),
    .mmreg_coreout_o (mmreg_coreout_o),
    .scan_start_o    (scan_start),
    .scan_base_o     (scan_base),
    .scan_count_o    (scan_count),
    .rvk_lo_o        (rvk_lo),
    .rvk_hi_o        (rvk_hi),
    .stk_base_o      (stk_base)
  );

  stack_zero_engine #(
    .IntrAbortEn (IntrAbortEn)
  ) u_stkz (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ztop_wr_i       (ztop_wr_i),
    .ztop_wdata_i    (ztop_wdata_i),
    .stk_base_i      (stk_base),
    .unmasked_intr_i (unmasked_intr_i),
    .ztop_rdata_o    (ztop_rdata_o),
    .stkz_active_o   (stkz_active_o),
    .stkz_abort_o    (stkz_abort_o),
    .stkz_ptr_o      (stkz_ptr_o),
    .stkz_err_o      (stkz_err),
    .req_o           (stkz_req),
    .we_o            (stkz_we),
    .addr_o          (stkz_addr),
    .wdata_o         (stkz_wdata),
    .req_done_i      (stkz_req_done),
    .resp_valid_i    (stkz_resp_valid),
    .resp_err_i      (lsu_resp_err_i)
  );

  tag_scan_engine #(
    .ScanCntW (ScanCntW)
  ) u_scan (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (scan_start),
    .base_i       (scan_base),
    .count_i      (scan_count),
    .rvk_lo_i     (rvk_lo),
    .rvk_hi_i     (rvk_hi),
    .busy_o       (scan_busy),
    .err_o        (scan_err),
    .req_o        (scan_req),
    .we_o         (scan_we),
    .addr_o       (scan_addr),
    .wdata_o      (scan_wdata),
    .req_done_i   (scan_req_done),
    .resp_valid_i (scan_resp_valid),
    .resp_err_i   (lsu_resp_err_i),
    .rdata_i      (lsu_resp_rdata_i)
  );

  lsu_port_arbiter u_arb (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .m0_req_i         (stkz_req),
    .m0_we_i          (stkz_we),
    .m0_addr_i        (stkz_addr),
    .m0_wdata_i       (stkz_wdata),
    .m0_req_done_o    (stkz_req_done),
    .m0_resp_valid_o  (stkz_resp_valid),
    .m1_req_i         (scan_req),
    .m1_we_i          (scan_we),
    .m1_addr_i        (scan_addr),
    .m1_wdata_i       (scan_wdata),
    .m1_req_done_o    (scan_req_done),
    .m1_resp_valid_o  (scan_resp_valid),
    .lsu_req_o        (lsu_req_o),
    .lsu_we_o         (lsu_we_o),
    .lsu_addr_o       (lsu_addr_o),
    .lsu_wdata_o      (lsu_wdata_o),
    .lsu_req_done_i   (lsu_req_done_i),
    .lsu_resp_valid_i (lsu_resp_valid_i)
  );

endmodule

// ==== hw/lsu_port_arbiter.sv ====
/*
  Two-master strict-priority arbiter for the shared load/store port.
  Master 0 wins ties; a pending decision is held until the port accepts it.
*/
`timescale 1ns/1ns

module lsu_port_arbiter import mem_eng_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,

  // Master 0, stack zeroing
  input  logic             m0_req_i,
  input  logic             m0_we_i,
  input  logic [31:0]      m0_addr_i,
  input  logic [WordW-1:0] m0_wdata_i,
  output logic             m0_req_done_o,
  output logic             m0_resp_valid_o,

  // Master 1, tag scan
  input  logic             m1_req_i,
  input  logic             m1_we_i,
  input  logic [31:0]      m1_addr_i,
  input  logic [WordW-1:0] m1_wdata_i,
  output logic             m1_req_done_o,
  output logic             m1_resp_valid_o,

  // Shared port
  output logic             lsu_req_o,
  output logic             lsu_we_o,
  output logic [31:0]      lsu_addr_o,
  output logic [WordW-1:0] lsu_wdata_o,
  input  logic             lsu_req_done_i,
  input  logic             lsu_resp_valid_i
);

  logic fresh_m1;
  logic sel_m1;
  logic sel_q;
  logic pend_q;
  logic pending;
  logic resp_sel_q;

  // Fresh decision, then the held one while a request waits
  assign fresh_m1 = m1_req_i & ~m0_req_i;
  assign sel_m1   = pend_q ? sel_q : fresh_m1;

  assign lsu_req_o = m0_req_i | m1_req_i;
  assign pending   = lsu_req_o & ~lsu_req_done_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q     <= 1'b0;
      sel_q      <= 1'b0;
      resp_sel_q <= 1'b0;
    end else begin
      pend_q <= pending;
      if (pending) begin
        sel_q <= sel_m1;
      end
      // Winner at acceptance owns the next response
      if (lsu_req_done_i) begin
        resp_sel_q <= sel_m1;
      end
    end
  end

  assign lsu_we_o    = sel_m1 ? m1_we_i    : m0_we_i;
  assign lsu_addr_o  = sel_m1 ? m1_addr_i  : m0_addr_i;
  assign lsu_wdata_o = sel_m1 ? m1_wdata_i : m0_wdata_i;

  assign m0_req_done_o   = lsu_req_done_i & m0_req_i & ~sel_m1;
  assign m1_req_done_o   = lsu_req_done_i & m1_req_i & sel_m1;
  assign m0_resp_valid_o = lsu_resp_valid_i & ~resp_sel_q;
  assign m1_resp_valid_o = lsu_resp_valid_i & resp_sel_q;

endmodule

// ==== hw/tag_scan_engine.sv ====
/*
  Tag-scan revocation engine. Reads each word of a range and writes back
  with the tag cleared any tagged word that points into the revoked window.
*/
`timescale 1ns/1ns

module tag_scan_engine import mem_eng_pkg::*; #(
  parameter int unsigned ScanCntW = 16
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Scan setup, stable from the start pulse on
  input  logic                start_i,
  input  logic [23:0]         base_i,
  input  logic [ScanCntW-1:0] count_i,
  input  logic [23:0]         rvk_lo_i,
  input  logic [23:0]         rvk_hi_i,
  output logic                busy_o,
  output logic                err_o,

  // Request toward the arbiter
  output logic                req_o,
  output logic                we_o,
  output logic [31:0]         addr_o,
  output logic [WordW-1:0]    wdata_o,
  input  logic                req_done_i,
  input  logic                resp_valid_i,
  input  logic                resp_err_i,
  input  logic [WordW-1:0]    rdata_i
);

  typedef enum logic [2:0] {
    ScanIdle,
    ScanRead,
    ScanWaitRd,
    ScanWrite,
    ScanWaitWr
  } scan_state_e;

  scan_state_e         state_q;
  logic [23:0]         addr_q;
  logic [ScanCntW-1:0] cnt_q;
  logic [WordW-1:0]    wb_q;
  logic                err_q;
  logic                in_window;
  logic                revoke;
  logic                last_word;

  assign in_window = (rdata_i[23:0] >= rvk_lo_i) && (rdata_i[23:0] < rvk_hi_i);
  assign revoke    = rdata_i[WordW-1] & in_window;
  assign last_word = (cnt_q == ScanCntW'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ScanIdle;
      addr_q  <= 24'h0;
      cnt_q   <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        ScanIdle: begin
          if (start_i) begin
            addr_q <= base_i;
            cnt_q  <= count_i;
            err_q  <= 1'b0;
            if (count_i != '0) begin
              state_q <= ScanRead;
            end
          end
        end
        ScanRead: begin
          if (req_done_i) begin
            state_q <= ScanWaitRd;
          end
        end
        ScanWaitRd: begin
          if (resp_valid_i) begin
            if (!resp_err_i && revoke) begin
              state_q <= ScanWrite;
            end else begin
              // Clean word or read error, move on
              err_q   <= err_q | resp_err_i;
              addr_q  <= addr_q + 24'd4;
              cnt_q   <= cnt_q - 1'b1;
              state_q <= last_word ? ScanIdle : ScanRead;
            end
          end
        end
        ScanWrite: begin
          if (req_done_i) begin
            state_q <= ScanWaitWr;
          end
        end
        ScanWaitWr: begin
          if (resp_valid_i) begin
            err_q   <= err_q | resp_err_i;
            addr_q  <= addr_q + 24'd4;
            cnt_q   <= cnt_q - 1'b1;
            state_q <= last_word ? ScanIdle : ScanRead;
          end
        end
        default: state_q <= ScanIdle;
      endcase
    end
  end

  // Write-back word keeps the low 32 bits and drops the tag
  always_ff @(posedge clk_i) begin
    if (state_q == ScanWaitRd && resp_valid_i) begin
      wb_q <= {1'b0, rdata_i[WordW-2:0]};
    end
  end

  assign req_o   = (state_q == ScanRead) || (state_q == ScanWrite);
  assign we_o    = (state_q == ScanWrite);
  assign addr_o  = {8'h00, addr_q};
  assign wdata_o = wb_q;
  assign busy_o  = (state_q != ScanIdle);
  assign err_o   = err_q;

endmodule

// ==== hw/stack_zero_engine.sv ====
/*
  Stack zeroing engine. A stack-top write above the base starts clearing
  words downward, one write at a time, until the pointer reaches the base.
*/
`timescale 1ns/1ns

module stack_zero_engine import mem_eng_pkg::*; #(
  parameter bit IntrAbortEn = 1'b1
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  // Stack-top register access
  input  logic             ztop_wr_i,
  input  logic [31:0]      ztop_wdata_i,
  input  logic [31:0]      stk_base_i,
  input  logic             unmasked_intr_i,
  output logic [31:0]      ztop_rdata_o,

  output logic             stkz_active_o,
  output logic             stkz_abort_o,
  output logic [31:0]      stkz_ptr_o,
  output logic             stkz_err_o,

  // Request toward the arbiter
  output logic             req_o,
  output logic             we_o,
  output logic [31:0]      addr_o,
  output logic [WordW-1:0] wdata_o,
  input  logic             req_done_i,
  input  logic             resp_valid_i,
  input  logic             resp_err_i
);

  logic [31:0] ptr_q;
  logic [31:0] ptr_dec;
  logic        active_q;
  logic        wait_q;
  logic        abort_q;
  logic        abort_pend_q;
  logic        err_q;
  logic        abort_req;
  logic        last_word;

  assign ptr_dec   = ptr_q - 32'd4;
  assign last_word = (ptr_dec <= stk_base_i);
  assign abort_req = IntrAbortEn & unmasked_intr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q        <= 32'h0;
      active_q     <= 1'b0;
      wait_q       <= 1'b0;
      abort_q      <= 1'b0;
      abort_pend_q <= 1'b0;
      err_q        <= 1'b0;
    end else begin
      abort_q <= 1'b0;
      if (!active_q) begin
        // A new stack top is taken only when the engine is idle
        if (ztop_wr_i) begin
          ptr_q <= ztop_wdata_i;
          if (ztop_wdata_i > stk_base_i) begin
            active_q <= 1'b1;
            err_q    <= 1'b0;
          end
        end
      end else begin
        // Interrupt is held until the word in flight completes
        if (abort_req) begin
          abort_pend_q <= 1'b1;
        end
        if (req_done_i) begin
          wait_q <= 1'b1;
        end
        if (resp_valid_i) begin
          wait_q <= 1'b0;
          ptr_q  <= ptr_dec;
          if (resp_err_i) begin
            err_q <= 1'b1;
          end
          if (last_word) begin
            active_q     <= 1'b0;
            abort_pend_q <= 1'b0;
          end else if (abort_pend_q || abort_req) begin
            active_q     <= 1'b0;
            abort_q      <= 1'b1;
            abort_pend_q <= 1'b0;
          end
        end
      end
    end
  end

  // One zero write outstanding at a time, address below the pointer
  assign req_o   = active_q & ~wait_q;
  assign we_o    = 1'b1;
  assign addr_o  = ptr_dec;
  assign wdata_o = '0;

  assign ztop_rdata_o  = ptr_q;
  assign stkz_ptr_o    = ptr_q;
  assign stkz_active_o = active_q;
  assign stkz_abort_o  = abort_q;
  assign stkz_err_o    = err_q;

endmodule

// ==== hw/mem_eng_ctrl.sv ====
/*
  Command decode and status packing for the memory engines.
  Turns the scan start bit into a start pulse and latches the scan setup.
*/
`timescale 1ns/1ns

module mem_eng_ctrl import mem_eng_pkg::*; #(
  parameter int unsigned ScanCntW = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic [MMRegDinW-1:0]  mmreg_corein_i,
  input  logic                  scan_busy_i,
  input  logic                  scan_err_i,
  input  logic                  stk_err_i,
  output logic [MMRegDoutW-1:0] mmreg_coreout_o,

  output logic                  scan_start_o,
  output logic [23:0]           scan_base_o,
  output logic [ScanCntW-1:0]   scan_count_o,
  output logic [23:0]           rvk_lo_o,
  output logic [23:0]           rvk_hi_o,
  output logic [31:0]           stk_base_o
);

  logic                  start_bit_q;
  logic                  start_rise;
  logic                  start_take;
  logic [MMRegDoutW-1:0] stat_d;

  assign start_rise = mmreg_corein_i[CMD_SCAN_START_BIT] & ~start_bit_q;

  // Drop a start while a scan runs
  assign start_take = start_rise & ~scan_busy_i;

  always_comb begin
    stat_d                 = '0;
    stat_d[STAT_SCAN_BUSY] = scan_busy_i;
    stat_d[STAT_SCAN_ERR]  = scan_err_i;
    stat_d[STAT_STK_ERR]   = stk_err_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_bit_q     <= 1'b0;
      scan_start_o    <= 1'b0;
      mmreg_coreout_o <= '0;
    end else begin
      start_bit_q     <= mmreg_corein_i[CMD_SCAN_START_BIT];
      scan_start_o    <= start_take;
      mmreg_coreout_o <= stat_d;
    end
  end

  // Scan setup is captured with the start so the engine sees a stable window
  always_ff @(posedge clk_i) begin
    if (start_take) begin
      scan_base_o  <= mmreg_corein_i[CMD_SCAN_BASE_LSB +: 24];
      scan_count_o <= mmreg_corein_i[CMD_SCAN_COUNT_LSB +: ScanCntW];
      rvk_lo_o     <= mmreg_corein_i[CMD_RVK_LO_LSB +: 24];
      rvk_hi_o     <= mmreg_corein_i[CMD_RVK_HI_LSB +: 24];
    end
  end

  // Stack base follows the command vector
  always_ff @(posedge clk_i) begin
    stk_base_o <= mmreg_corein_i[CMD_STK_BASE_LSB +: 32];
  end

endmodule

// ==== hw/mem_eng_pkg.sv ====
/*
  Shared widths and field positions for the memory engine subsystem.
  Imported by the control block, both engines, the arbiter and the top level.
*/
package mem_eng_pkg;

  // Command vector from the core and status word back to it
  parameter int unsigned MMRegDinW  = 128;
  parameter int unsigned MMRegDoutW = 64;

  // Tagged memory word, the tag is the top bit
  parameter int unsigned WordW = 33;

  // Command field positions
  parameter int unsigned CMD_SCAN_START_BIT = 0;
  // Scan base, 24 bits, word aligned byte address
  parameter int unsigned CMD_SCAN_BASE_LSB  = 1;
  // Scan word count, 16 bits
  parameter int unsigned CMD_SCAN_COUNT_LSB = 25;
  // Revoked window, low bound included and high bound excluded
  parameter int unsigned CMD_RVK_LO_LSB     = 41;
  parameter int unsigned CMD_RVK_HI_LSB     = 65;
  // Stack base sits in the top 32 bits
  parameter int unsigned CMD_STK_BASE_LSB   = 96;

  // Status word bit positions
  parameter int unsigned STAT_SCAN_BUSY = 0;
  parameter int unsigned STAT_SCAN_ERR  = 1;
  parameter int unsigned STAT_STK_ERR   = 2;

endpackage
